//--- verilog.f
rtl/ring_dma_pkg.sv
rtl/ring_write_engine.sv
rtl/ring_read_engine.sv
rtl/mem_port_arbiter.sv
rtl/ring_dma_top.sv
verif/mem_model.sv
verif/ring_dma_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module ring_dma_tb -o ring_dma_sim

sim_out=$(./obj_dir/ring_dma_sim)
echo "$sim_out"

echo "$sim_out" | grep -q "^TB PASSED$"

//--- verif/ring_dma_tb.sv
`default_nettype none

module ring_dma_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RING_BEATS = 64;
  localparam int MAX_BURST  = 16;
  localparam logic [31:0] RING_BASE = '0;
  localparam int TOTAL_BEATS = 300 + 40 + RING_BEATS + 16 + 20;
  localparam int BEAT_CYCLES = 24;
  localparam int HOLD_CYCLES = 400;
  localparam int WATCHDOG_NS = (TOTAL_BEATS * BEAT_CYCLES + HOLD_CYCLES + 200) * 10;

  logic clk;
  logic rst;
  logic active_i;
  logic flush_i;
  logic out_afull_i;
  logic [511:0] in_data_i;
  logic [31:0] in_count_i;
  logic in_rd_en_o;
  logic [511:0] out_data_o;
  logic out_wr_en_o;
  logic mem_cmd_valid_o;
  logic mem_cmd_write_o;
  logic [31:0] mem_cmd_addr_o;
  logic [7:0] mem_cmd_len_o;
  logic mem_cmd_ready_i;
  logic [511:0] mem_wdata_o;
  logic mem_wvalid_o;
  logic mem_wlast_o;
  logic mem_wready_i;
  logic mem_wack_i;
  logic [511:0] mem_rdata_i;
  logic mem_rvalid_i;
  logic mem_rlast_i;

  // controls applied on the next falling edge
  bit act;
  bit flush;
  bit afull;
  int seed = 98;
  logic [511:0] in_q[$];
  logic [511:0] exp_q[$];
  int wr_pos;
  int rd_pos;
  int wr_left;
  bit rbeat_prev;
  int pops;
  int cur;
  int errs[6];
  string test_name[6] = '{"stream_integrity", "memory_byte_order", "burst_shape",
                          "flush_remainder", "back_pressure", "inactive"};

  ring_dma_top #(
    .RING_BEATS (RING_BEATS),
    .MAX_BURST  (MAX_BURST),
    .RING_BASE  (RING_BASE)
  ) dut_i (
    .clk (clk), .rst (rst), .active_i (active_i), .flush_i (flush_i),
    .in_data_i (in_data_i), .in_count_i (in_count_i), .in_rd_en_o (in_rd_en_o),
    .out_data_o (out_data_o), .out_wr_en_o (out_wr_en_o), .out_afull_i (out_afull_i),
    .mem_cmd_valid_o (mem_cmd_valid_o), .mem_cmd_write_o (mem_cmd_write_o),
    .mem_cmd_addr_o (mem_cmd_addr_o), .mem_cmd_len_o (mem_cmd_len_o),
    .mem_cmd_ready_i (mem_cmd_ready_i), .mem_wdata_o (mem_wdata_o),
    .mem_wvalid_o (mem_wvalid_o), .mem_wlast_o (mem_wlast_o),
    .mem_wready_i (mem_wready_i), .mem_wack_i (mem_wack_i),
    .mem_rdata_i (mem_rdata_i), .mem_rvalid_i (mem_rvalid_i), .mem_rlast_i (mem_rlast_i)
  );

  mem_model mem_i (
    .clk (clk), .rst (rst), .cmd_valid_i (mem_cmd_valid_o), .cmd_write_i (mem_cmd_write_o),
    .cmd_addr_i (mem_cmd_addr_o), .cmd_len_i (mem_cmd_len_o), .cmd_ready_o (mem_cmd_ready_i),
    .wdata_i (mem_wdata_o), .wvalid_i (mem_wvalid_o), .wlast_i (mem_wlast_o),
    .wready_o (mem_wready_i), .wack_o (mem_wack_i), .rdata_o (mem_rdata_i),
    .rvalid_o (mem_rvalid_i), .rlast_o (mem_rlast_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the DUT stopped making progress");
    $display("TB FAILED");
    $finish;
  end

  // bytes reversed inside each 64-bit lane
  function automatic logic [511:0] reverse_lane_bytes(input logic [511:0] b);
    logic [511:0] r;
    for (int l = 0; l < 8; l++) begin
      for (int k = 0; k < 8; k++) begin
        r[l*64 + k*8 +: 8] = b[l*64 + (7-k)*8 +: 8];
      end
    end
    return r;
  endfunction

  task automatic value_error(input int idx, input logic [511:0] exp_v, input logic [511:0] got);
    errs[idx]++;
    $display("[ERROR] %s: expected %h actual %h", test_name[idx], exp_v, got);
  endtask

  task automatic plain_error(input int idx, input string msg);
    errs[idx]++;
    $display("%s: %s", test_name[idx], msg);
  endtask

  task automatic check_command();
    int len;
    int slot;
    logic [31:0] exp_addr;
    len  = int'(mem_cmd_len_o) + 1;
    slot = int'((mem_cmd_addr_o - RING_BASE) / 64);
    if (mem_cmd_addr_o % 64 != 0) plain_error(2, "command address not beat aligned");
    if (len > MAX_BURST) plain_error(2, "burst longer than the maximum");
    if (slot + len > RING_BEATS) plain_error(2, "burst crosses the ring end");
    if (mem_cmd_write_o) begin
      exp_addr = RING_BASE + 32'((wr_pos % RING_BEATS) * 64);
      wr_left  = len;
      if (!flush_i && len != MAX_BURST && slot + len != RING_BEATS) begin
        plain_error(2, "short write burst without flush");
      end
    end else begin
      exp_addr = RING_BASE + 32'((rd_pos % RING_BEATS) * 64);
      if (out_afull_i) plain_error(4, "read command issued while output FIFO almost full");
    end
    if (mem_cmd_addr_o != exp_addr) value_error(2, 512'(exp_addr), 512'(mem_cmd_addr_o));
  endtask

  task automatic check_write_beat();
    if (!in_rd_en_o) plain_error(cur, "write beat accepted without popping the input FIFO");
    if (mem_wlast_o !== (wr_left == 1)) begin
      value_error(2, 512'(wr_left == 1), 512'(mem_wlast_o));
    end
    wr_left--;
    if (in_q.size() == 0) begin
      plain_error(cur, "write beat with an empty input FIFO");
    end else begin
      if (mem_wdata_o !== reverse_lane_bytes(in_q[0])) begin
        value_error(1, reverse_lane_bytes(in_q[0]), mem_wdata_o);
      end
      void'(in_q.pop_front());
      wr_pos++;
      pops++;
    end
  endtask

  // drive on the falling edge and sample just before the rising edge
  task automatic step();
    @(negedge clk);
    active_i    = act;
    flush_i     = flush;
    out_afull_i = afull;
    in_count_i  = 32'(in_q.size());
    in_data_i   = (in_q.size() > 0) ? in_q[0] : '0;
    #4;
    if (!active_i && (mem_cmd_valid_o || in_rd_en_o)) begin
      plain_error(5, "memory command or FIFO pop while inactive");
    end
    if (mem_cmd_valid_o && mem_cmd_ready_i) check_command();
    if (mem_wvalid_o && mem_wready_i) begin
      check_write_beat();
    end else if (in_rd_en_o) begin
      plain_error(cur, "input FIFO popped without a write beat");
    end
    if (mem_rvalid_i) rd_pos++;
    if (out_wr_en_o !== rbeat_prev) begin
      plain_error(cur, "output write not one cycle after the read beat");
    end
    rbeat_prev = mem_rvalid_i;
    if (out_wr_en_o) begin
      if (exp_q.size() == 0) begin
        plain_error(cur, "output beat with nothing expected");
      end else begin
        if (out_data_o !== exp_q[0]) value_error(cur, exp_q[0], out_data_o);
        void'(exp_q.pop_front());
      end
    end
  endtask

  task automatic push_beats(input int n);
    logic [511:0] b;
    for (int i = 0; i < n; i++) begin
      for (int w = 0; w < 16; w++) begin
        b[w*32 +: 32] = $random(seed);
      end
      in_q.push_back(b);
      exp_q.push_back(b);
    end
  endtask

  task automatic hold_cycles(input int n);
    repeat (n) step();
  endtask

  // only a partial burst left and everything written has come out
  task automatic wait_remainder(input int max_cycles);
    int n;
    n = 0;
    while (!(in_q.size() < MAX_BURST && exp_q.size() == in_q.size()) && n < max_cycles) begin
      step();
      n++;
    end
    if (n >= max_cycles) plain_error(cur, "timed out waiting for full bursts to finish");
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || in_q.size() != 0) && n < max_cycles) begin
      step();
      n++;
    end
    if (n >= max_cycles) plain_error(cur, "timed out waiting for the stream to drain");
  endtask

  task automatic report_test(input int idx);
    $display("test %-18s %s (%0d errors)", test_name[idx], errs[idx] == 0 ? "ok" : "failed",
             errs[idx]);
  endtask

  initial begin
    int failed;
    int n;
    rst = 1'b1;
    active_i = 1'b0;
    flush_i = 1'b0;
    out_afull_i = 1'b0;
    in_data_i = '0;
    in_count_i = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    act = 1'b1;

    cur = 0;
    push_beats(300);
    wait_remainder(300 * BEAT_CYCLES);
    flush = 1'b1;
    wait_drained(MAX_BURST * BEAT_CYCLES);
    flush = 1'b0;
    report_test(0);

    // leftover must wait for flush
    cur = 3;
    push_beats(40);
    wait_remainder(40 * BEAT_CYCLES);
    hold_cycles(100);
    if (in_q.size() == 0 || exp_q.size() != in_q.size()) begin
      plain_error(3, "leftover beats moved without flush");
    end
    flush = 1'b1;
    wait_drained(MAX_BURST * BEAT_CYCLES);
    flush = 1'b0;
    report_test(3);

    cur = 4;
    afull = 1'b1;
    pops = 0;
    push_beats(RING_BEATS + 16);
    n = 0;
    while (pops <= RING_BEATS - MAX_BURST && n < RING_BEATS * BEAT_CYCLES) begin
      step();
      n++;
    end
    if (n >= RING_BEATS * BEAT_CYCLES) plain_error(4, "timed out filling the ring");
    hold_cycles(100);
    if (pops > RING_BEATS) plain_error(4, "writer overran the ring");
    afull = 1'b0;
    flush = 1'b1;
    wait_drained((RING_BEATS + 16) * BEAT_CYCLES);
    flush = 1'b0;
    report_test(4);

    // restart must begin at the ring base again
    cur = 5;
    act = 1'b0;
    hold_cycles(5);
    wr_pos = 0;
    rd_pos = 0;
    push_beats(20);
    hold_cycles(50);
    if (in_q.size() != 20) plain_error(5, "input FIFO drained while inactive");
    act = 1'b1;
    flush = 1'b1;
    wait_drained(20 * BEAT_CYCLES);
    flush = 1'b0;
    report_test(5);

    report_test(1);
    report_test(2);
    failed = 0;
    foreach (errs[i]) begin
      if (errs[i] != 0) failed++;
    end
    $display("tests run 6, tests failed %0d", failed);
    if (failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/mem_model.sv
`default_nettype none

module mem_model #(
  parameter int DEPTH = 256
) (
  input  wire          clk,
  input  wire          rst,
  input  wire          cmd_valid_i,
  input  wire          cmd_write_i,
  input  wire [31:0]   cmd_addr_i,
  input  wire [7:0]    cmd_len_i,
  output logic         cmd_ready_o,
  input  wire [511:0]  wdata_i,
  input  wire          wvalid_i,
  input  wire          wlast_i,
  output logic         wready_o,
  output logic         wack_o,
  output logic [511:0] rdata_o,
  output logic         rvalid_o,
  output logic         rlast_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [511:0] mem [DEPTH];
  int seed = 98;
  bit busy;
  bit in_reset = 1'b1;
  int wr_idx;
  int rd_idx;
  int rd_left;
  int wack_wait;

  // reset state as seen at the last rising edge
  always @(posedge clk) begin
    in_reset <= rst;
  end

  initial begin
    cmd_ready_o = 1'b0;
    wready_o    = 1'b0;
    wack_o      = 1'b0;
    rdata_o     = '0;
    rvalid_o    = 1'b0;
    rlast_o     = 1'b0;
    forever begin
      @(negedge clk);
      if (in_reset) begin
        busy      = 1'b0;
        rd_left   = 0;
        wack_wait = 0;
        cmd_ready_o = 1'b0;
        wready_o    = 1'b0;
        wack_o      = 1'b0;
        rvalid_o    = 1'b0;
        rlast_o     = 1'b0;
      end else begin
        // random stalls on both ready lines
        cmd_ready_o = !busy && (($random(seed) & 3) != 0);
        wready_o    = ($random(seed) & 3) != 0;
        wack_o      = 1'b0;
        if (wack_wait > 0) begin
          wack_wait = wack_wait - 1;
          wack_o    = (wack_wait == 0);
        end
        // read beats with random gaps
        rvalid_o = (rd_left > 0) && (($random(seed) & 1) != 0);
        rdata_o  = mem[rd_idx % DEPTH];
        rlast_o  = rvalid_o && (rd_left == 1);
        #4;
        if (cmd_valid_i && cmd_ready_o) begin
          busy = 1'b1;
          if (cmd_write_i) begin
            wr_idx = int'(cmd_addr_i / 64);
          end else begin
            rd_idx  = int'(cmd_addr_i / 64);
            rd_left = int'(cmd_len_i) + 1;
          end
        end
        if (wvalid_i && wready_o) begin
          mem[wr_idx % DEPTH] = wdata_i;
          wr_idx = wr_idx + 1;
          if (wlast_i) begin
            wack_wait = 1 + ($random(seed) & 3);
          end
        end
        if (wack_o) begin
          busy = 1'b0;
        end
        if (rvalid_o) begin
          rd_idx  = rd_idx + 1;
          rd_left = rd_left - 1;
          if (rlast_o) begin
            busy = 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/ring_dma_top.sv
`default_nettype none

module ring_dma_top #(
  parameter int RING_BEATS = 64,
  parameter int MAX_BURST  = 16,
  parameter logic [ring_dma_pkg::ADDR_W-1:0] RING_BASE = '0
) (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                active_i,
  input  wire                                flush_i,
  // input fifo, show-ahead
  input  wire ring_dma_pkg::beat_t           in_data_i,
  input  wire [ring_dma_pkg::ADDR_W-1:0]     in_count_i,
  output logic                               in_rd_en_o,
  // output fifo
  output ring_dma_pkg::beat_t                out_data_o,
  output logic                               out_wr_en_o,
  input  wire                                out_afull_i,
  // burst memory port
  output logic                               mem_cmd_valid_o,
  output logic                               mem_cmd_write_o,
  output logic [ring_dma_pkg::ADDR_W-1:0]    mem_cmd_addr_o,
  output logic [ring_dma_pkg::LEN_W-1:0]     mem_cmd_len_o,
  input  wire                                mem_cmd_ready_i,
  output ring_dma_pkg::beat_t                mem_wdata_o,
  output logic                               mem_wvalid_o,
  output logic                               mem_wlast_o,
  input  wire                                mem_wready_i,
  input  wire                                mem_wack_i,
  input  wire ring_dma_pkg::beat_t           mem_rdata_i,
  input  wire                                mem_rvalid_i,
  input  wire                                mem_rlast_i
);

  localparam int PW = $clog2(RING_BEATS) + 1;

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;

  logic                             wr_cmd_valid;
  logic [ring_dma_pkg::ADDR_W-1:0]  wr_cmd_addr;
  logic [ring_dma_pkg::LEN_W-1:0]   wr_cmd_len;
  logic                             wr_cmd_ready;
  ring_dma_pkg::beat_t              wr_wdata;
  logic                             wr_wvalid;
  logic                             wr_wlast;
  logic                             wr_wready;
  logic                             wr_wack;

  logic                             rd_cmd_valid;
  logic [ring_dma_pkg::ADDR_W-1:0]  rd_cmd_addr;
  logic [ring_dma_pkg::LEN_W-1:0]   rd_cmd_len;
  logic                             rd_cmd_ready;
  ring_dma_pkg::beat_t              rd_rdata;
  logic                             rd_rvalid;
  logic                             rd_rlast;

  ring_write_engine #(
    .RING_BEATS (RING_BEATS),
    .MAX_BURST  (MAX_BURST),
    .RING_BASE  (RING_BASE)
  ) write_engine_i (
    .clk         (clk),
    .rst         (rst),
    .active_i    (active_i),
    .flush_i     (flush_i),
    .in_data_i   (in_data_i),
    .in_count_i  (in_count_i),
    .rd_ptr_i    (rd_ptr),
    .cmd_ready_i (wr_cmd_ready),
    .wready_i    (wr_wready),
    .wack_i      (wr_wack),
    .in_rd_en_o  (in_rd_en_o),
    .cmd_valid_o (wr_cmd_valid),
    .cmd_addr_o  (wr_cmd_addr),
    .cmd_len_o   (wr_cmd_len),
    .wdata_o     (wr_wdata),
    .wvalid_o    (wr_wvalid),
    .wlast_o     (wr_wlast),
    .wr_ptr_o    (wr_ptr)
  );

  ring_read_engine #(
    .RING_BEATS (RING_BEATS),
    .MAX_BURST  (MAX_BURST),
    .RING_BASE  (RING_BASE)
  ) read_engine_i (
    .clk         (clk),
    .rst         (rst),
    .active_i    (active_i),
    .wr_ptr_i    (wr_ptr),
    .out_afull_i (out_afull_i),
    .cmd_ready_i (rd_cmd_ready),
    .rdata_i     (rd_rdata),
    .rvalid_i    (rd_rvalid),
    .rlast_i     (rd_rlast),
    .cmd_valid_o (rd_cmd_valid),
    .cmd_addr_o  (rd_cmd_addr),
    .cmd_len_o   (rd_cmd_len),
    .rd_ptr_o    (rd_ptr),
    .out_data_o  (out_data_o),
    .out_wr_en_o (out_wr_en_o)
  );

  mem_port_arbiter arbiter_i (
    .clk             (clk),
    .rst             (rst),
    .wr_cmd_valid_i  (wr_cmd_valid),
    .wr_cmd_addr_i   (wr_cmd_addr),
    .wr_cmd_len_i    (wr_cmd_len),
    .wr_wdata_i      (wr_wdata),
    .wr_wvalid_i     (wr_wvalid),
    .wr_wlast_i      (wr_wlast),
    .wr_cmd_ready_o  (wr_cmd_ready),
    .wr_wready_o     (wr_wready),
    .wr_wack_o       (wr_wack),
    .rd_cmd_valid_i  (rd_cmd_valid),
    .rd_cmd_addr_i   (rd_cmd_addr),
    .rd_cmd_len_i    (rd_cmd_len),
    .rd_cmd_ready_o  (rd_cmd_ready),
    .rd_rdata_o      (rd_rdata),
    .rd_rvalid_o     (rd_rvalid),
    .rd_rlast_o      (rd_rlast),
    .mem_cmd_valid_o (mem_cmd_valid_o),
    .mem_cmd_write_o (mem_cmd_write_o),
    .mem_cmd_addr_o  (mem_cmd_addr_o),
    .mem_cmd_len_o   (mem_cmd_len_o),
    .mem_cmd_ready_i (mem_cmd_ready_i),
    .mem_wdata_o     (mem_wdata_o),
    .mem_wvalid_o    (mem_wvalid_o),
    .mem_wlast_o     (mem_wlast_o),
    .mem_wready_i    (mem_wready_i),
    .mem_wack_i      (mem_wack_i),
    .mem_rdata_i     (mem_rdata_i),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rlast_i     (mem_rlast_i)
  );

endmodule

`default_nettype wire

//--- rtl/mem_port_arbiter.sv
`default_nettype none

module mem_port_arbiter (
  input  wire                                clk,
  input  wire                                rst,
  // write engine side
  input  wire                                wr_cmd_valid_i,
  input  wire [ring_dma_pkg::ADDR_W-1:0]     wr_cmd_addr_i,
  input  wire [ring_dma_pkg::LEN_W-1:0]      wr_cmd_len_i,
  input  wire ring_dma_pkg::beat_t           wr_wdata_i,
  input  wire                                wr_wvalid_i,
  input  wire                                wr_wlast_i,
  output logic                               wr_cmd_ready_o,
  output logic                               wr_wready_o,
  output logic                               wr_wack_o,
  // read engine side
  input  wire                                rd_cmd_valid_i,
  input  wire [ring_dma_pkg::ADDR_W-1:0]     rd_cmd_addr_i,
  input  wire [ring_dma_pkg::LEN_W-1:0]      rd_cmd_len_i,
  output logic                               rd_cmd_ready_o,
  output ring_dma_pkg::beat_t                rd_rdata_o,
  output logic                               rd_rvalid_o,
  output logic                               rd_rlast_o,
  // shared memory port
  output logic                               mem_cmd_valid_o,
  output logic                               mem_cmd_write_o,
  output logic [ring_dma_pkg::ADDR_W-1:0]    mem_cmd_addr_o,
  output logic [ring_dma_pkg::LEN_W-1:0]     mem_cmd_len_o,
  input  wire                                mem_cmd_ready_i,
  output ring_dma_pkg::beat_t                mem_wdata_o,
  output logic                               mem_wvalid_o,
  output logic                               mem_wlast_o,
  input  wire                                mem_wready_i,
  input  wire                                mem_wack_i,
  input  wire ring_dma_pkg::beat_t           mem_rdata_i,
  input  wire                                mem_rvalid_i,
  input  wire                                mem_rlast_i
);

  localparam logic [1:0] A_IDLE = 2'd0;
  localparam logic [1:0] A_WR   = 2'd1;
  localparam logic [1:0] A_RD   = 2'd2;

  logic [1:0] owner_q;
  logic       last_wr_q;
  logic       pick_wr;
  logic       wr_own;
  logic       rd_own;

  // on a tie the engine not served last wins
  assign pick_wr = wr_cmd_valid_i && (!rd_cmd_valid_i || !last_wr_q);
  assign wr_own  = (owner_q == A_WR);
  assign rd_own  = (owner_q == A_RD);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      owner_q   <= A_IDLE;
      last_wr_q <= 1'b0;
    end else begin
      case (owner_q)
        A_IDLE: begin
          if (wr_cmd_valid_i || rd_cmd_valid_i) begin
            owner_q   <= pick_wr ? A_WR : A_RD;
            last_wr_q <= pick_wr;
          end
        end
        // held until the burst has fully completed
        A_WR: if (mem_wack_i) owner_q <= A_IDLE;
        A_RD: if (mem_rvalid_i && mem_rlast_i) owner_q <= A_IDLE;
        default: owner_q <= A_IDLE;
      endcase
    end
  end

  assign mem_cmd_valid_o = (wr_own && wr_cmd_valid_i) || (rd_own && rd_cmd_valid_i);
  assign mem_cmd_write_o = wr_own;
  assign mem_cmd_addr_o  = wr_own ? wr_cmd_addr_i : rd_cmd_addr_i;
  assign mem_cmd_len_o   = wr_own ? wr_cmd_len_i : rd_cmd_len_i;

  assign mem_wdata_o  = wr_wdata_i;
  assign mem_wvalid_o = wr_own && wr_wvalid_i;
  assign mem_wlast_o  = wr_own && wr_wlast_i;

  // responses only reach the owner
  assign wr_cmd_ready_o = wr_own && mem_cmd_ready_i;
  assign wr_wready_o    = wr_own && mem_wready_i;
  assign wr_wack_o      = wr_own && mem_wack_i;
  assign rd_cmd_ready_o = rd_own && mem_cmd_ready_i;
  assign rd_rdata_o     = mem_rdata_i;
  assign rd_rvalid_o    = rd_own && mem_rvalid_i;
  assign rd_rlast_o     = rd_own && mem_rlast_i;

endmodule

`default_nettype wire

//--- rtl/ring_read_engine.sv
`default_nettype none

module ring_read_engine #(
  parameter int RING_BEATS = 64,
  parameter int MAX_BURST  = 16,
  parameter logic [ring_dma_pkg::ADDR_W-1:0] RING_BASE = '0
) (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                active_i,
  input  wire [$clog2(RING_BEATS):0]         wr_ptr_i,
  input  wire                                out_afull_i,
  input  wire                                cmd_ready_i,
  input  wire ring_dma_pkg::beat_t           rdata_i,
  input  wire                                rvalid_i,
  input  wire                                rlast_i,
  output logic                               cmd_valid_o,
  output logic [ring_dma_pkg::ADDR_W-1:0]    cmd_addr_o,
  output logic [ring_dma_pkg::LEN_W-1:0]     cmd_len_o,
  output logic [$clog2(RING_BEATS):0]        rd_ptr_o,
  output ring_dma_pkg::beat_t                out_data_o,
  output logic                               out_wr_en_o
);

  localparam int AW = ring_dma_pkg::ADDR_W;
  localparam int LW = ring_dma_pkg::LEN_W;
  localparam int IW = $clog2(RING_BEATS);
  localparam int PW = IW + 1;

  localparam logic [1:0] R_INACTIVE = 2'd0;
  localparam logic [1:0] R_WAIT     = 2'd1;
  localparam logic [1:0] R_REQ      = 2'd2;
  localparam logic [1:0] R_READ     = 2'd3;

  logic [1:0]          state_q;
  logic [PW-1:0]       rd_ptr_q;
  logic [AW-1:0]       addr_q;
  logic [LW-1:0]       len_q;
  logic                out_wr_en_q;
  ring_dma_pkg::beat_t out_data_q;

  logic [PW-1:0] stored_beats;
  logic [PW-1:0] to_end;
  logic [PW-1:0] burst_beats;
  logic          start;
  logic          beat_in;

  assign stored_beats = wr_ptr_i - rd_ptr_q;
  assign to_end       = PW'(RING_BEATS) - PW'(rd_ptr_q[IW-1:0]);
  assign start        = (stored_beats != '0) && !out_afull_i;
  assign beat_in      = (state_q == R_READ) && rvalid_i;

  always_comb begin
    burst_beats = PW'(MAX_BURST);
    if (stored_beats < burst_beats) begin
      burst_beats = stored_beats;
    end
    if (to_end < burst_beats) begin
      burst_beats = to_end;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q     <= R_INACTIVE;
      rd_ptr_q    <= '0;
      out_wr_en_q <= 1'b0;
    end else begin
      out_wr_en_q <= beat_in;
      case (state_q)
        R_INACTIVE: begin
          rd_ptr_q <= '0;
          if (active_i) begin
            state_q <= R_WAIT;
          end
        end
        R_WAIT: begin
          if (!active_i) begin
            state_q  <= R_INACTIVE;
            rd_ptr_q <= '0;
          end else if (start) begin
            state_q <= R_REQ;
          end
        end
        R_REQ: begin
          if (cmd_ready_i) begin
            state_q <= R_READ;
          end
        end
        R_READ: begin
          // one slot freed per returned beat
          if (rvalid_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
            if (rlast_i) begin
              state_q <= R_WAIT;
            end
          end
        end
        default: state_q <= R_INACTIVE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == R_WAIT && active_i && start) begin
      addr_q <= RING_BASE + AW'(rd_ptr_q[IW-1:0]) * AW'(ring_dma_pkg::BEAT_BYTES);
      len_q  <= LW'(burst_beats - PW'(1));
    end
    if (beat_in) begin
      out_data_q <= ring_dma_pkg::swap_lanes(rdata_i);
    end
  end

  assign cmd_valid_o = (state_q == R_REQ);
  assign cmd_addr_o  = addr_q;
  assign cmd_len_o   = len_q;
  assign rd_ptr_o    = rd_ptr_q;
  assign out_data_o  = out_data_q;
  assign out_wr_en_o = out_wr_en_q;

endmodule

`default_nettype wire

//--- rtl/ring_write_engine.sv
`default_nettype none

module ring_write_engine #(
  parameter int RING_BEATS = 64,
  parameter int MAX_BURST  = 16,
  parameter logic [ring_dma_pkg::ADDR_W-1:0] RING_BASE = '0
) (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                active_i,
  input  wire                                flush_i,
  input  wire ring_dma_pkg::beat_t           in_data_i,
  input  wire [ring_dma_pkg::ADDR_W-1:0]     in_count_i,
  input  wire [$clog2(RING_BEATS):0]         rd_ptr_i,
  input  wire                                cmd_ready_i,
  input  wire                                wready_i,
  input  wire                                wack_i,
  output logic                               in_rd_en_o,
  output logic                               cmd_valid_o,
  output logic [ring_dma_pkg::ADDR_W-1:0]    cmd_addr_o,
  output logic [ring_dma_pkg::LEN_W-1:0]     cmd_len_o,
  output ring_dma_pkg::beat_t                wdata_o,
  output logic                               wvalid_o,
  output logic                               wlast_o,
  output logic [$clog2(RING_BEATS):0]        wr_ptr_o
);

  localparam int AW = ring_dma_pkg::ADDR_W;
  localparam int LW = ring_dma_pkg::LEN_W;
  localparam int IW = $clog2(RING_BEATS);
  localparam int PW = IW + 1;

  localparam logic [2:0] S_INACTIVE = 3'd0;
  localparam logic [2:0] S_WAIT     = 3'd1;
  localparam logic [2:0] S_REQ      = 3'd2;
  localparam logic [2:0] S_WRITE    = 3'd3;
  localparam logic [2:0] S_WACK     = 3'd4;

  logic [2:0]    state_q;
  logic [PW-1:0] wr_ptr_q;
  logic [AW-1:0] addr_q;
  logic [LW-1:0] len_q;
  logic [LW-1:0] beat_cnt_q;

  logic [PW-1:0] used_beats;
  logic [PW-1:0] free_beats;
  logic [PW-1:0] to_end;
  logic [AW-1:0] burst_beats;
  logic          start;
  logic          beat_xfer;

  // lap bit tells a full ring from an empty one
  assign used_beats = wr_ptr_q - rd_ptr_i;
  assign free_beats = PW'(RING_BEATS) - used_beats;
  assign to_end     = PW'(RING_BEATS) - PW'(wr_ptr_q[IW-1:0]);

  // full bursts normally, any remainder while flushing
  assign start = (in_count_i >= AW'(MAX_BURST) && free_beats >= PW'(MAX_BURST)) ||
                 (flush_i && in_count_i != '0 && free_beats != '0);

  // smallest of fifo level, ring end, free space and max burst
  always_comb begin
    burst_beats = AW'(MAX_BURST);
    if (in_count_i < burst_beats) begin
      burst_beats = in_count_i;
    end
    if (AW'(to_end) < burst_beats) begin
      burst_beats = AW'(to_end);
    end
    if (AW'(free_beats) < burst_beats) begin
      burst_beats = AW'(free_beats);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q    <= S_INACTIVE;
      wr_ptr_q   <= '0;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        S_INACTIVE: begin
          wr_ptr_q <= '0;
          if (active_i) begin
            state_q <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (!active_i) begin
            state_q  <= S_INACTIVE;
            wr_ptr_q <= '0;
          end else if (start) begin
            state_q <= S_REQ;
          end
        end
        S_REQ: begin
          if (cmd_ready_i) begin
            state_q    <= S_WRITE;
            beat_cnt_q <= '0;
          end
        end
        S_WRITE: begin
          if (beat_xfer) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (beat_cnt_q == len_q) begin
              state_q <= S_WACK;
            end
          end
        end
        S_WACK: begin
          // data is in memory only now, so the reader may see it
          if (wack_i) begin
            wr_ptr_q <= wr_ptr_q + PW'(len_q) + PW'(1);
            state_q  <= S_WAIT;
          end
        end
        default: state_q <= S_INACTIVE;
      endcase
    end
  end

  // command fields latched when the burst is sized
  always_ff @(posedge clk) begin
    if (state_q == S_WAIT && active_i && start) begin
      addr_q <= RING_BASE + AW'(wr_ptr_q[IW-1:0]) * AW'(ring_dma_pkg::BEAT_BYTES);
      len_q  <= LW'(burst_beats - AW'(1));
    end
  end

  assign cmd_valid_o = (state_q == S_REQ);
  assign cmd_addr_o  = addr_q;
  assign cmd_len_o   = len_q;

  // show-ahead fifo, pop on the accepted beat
  assign wvalid_o   = (state_q == S_WRITE);
  assign wlast_o    = wvalid_o && (beat_cnt_q == len_q);
  assign beat_xfer  = wvalid_o && wready_i;
  assign in_rd_en_o = beat_xfer;
  assign wdata_o    = ring_dma_pkg::swap_lanes(in_data_i);

  assign wr_ptr_o = wr_ptr_q;

endmodule

`default_nettype wire

//--- rtl/ring_dma_pkg.sv
`default_nettype none

package ring_dma_pkg;

  // beat geometry
  localparam int DATA_W     = 512;
  localparam int LANE_W     = 64;
  localparam int LANES      = DATA_W / LANE_W;
  localparam int BEAT_BYTES = DATA_W / 8;

  // memory command fields
  localparam int ADDR_W = 32;
  // burst length counts beats minus one
  localparam int LEN_W  = 8;

  // one data beat, seen flat or as lanes of bytes
  typedef union packed {
    logic [DATA_W-1:0]                     flat;
    logic [LANES-1:0][LANE_W/8-1:0][7:0]   lane;
  } beat_t;

  // reverse byte order inside every 64-bit lane
  function automatic beat_t swap_lanes(input beat_t beat);
    beat_t swapped;
    for (int l = 0; l < LANES; l++) begin
      for (int b = 0; b < LANE_W / 8; b++) begin
        swapped.lane[l][b] = beat.lane[l][LANE_W/8-1-b];
      end
    end
    return swapped;
  endfunction

endpackage

`default_nettype wire
